// ==== verilog/alu_pkg.sv ====
/* ALU coprocessor shared definitions */

package alu_pkg;

  // operator code width carried in the low bits of a command word
  localparam int ALU_OP_WIDTH = 6;

  // word address width of the register map
  localparam int REG_ADR_WIDTH = 5;

  // register map
  localparam logic [REG_ADR_WIDTH-1:0] REG_OPA    = 5'h00;
  localparam logic [REG_ADR_WIDTH-1:0] REG_OPB    = 5'h04;
  localparam logic [REG_ADR_WIDTH-1:0] REG_CMD    = 5'h08;
  localparam logic [REG_ADR_WIDTH-1:0] REG_RESULT = 5'h0C;
  localparam logic [REG_ADR_WIDTH-1:0] REG_STATUS = 5'h10;

  // single cycle group first, multiply/divide group from 0x20 up
  typedef enum logic [ALU_OP_WIDTH-1:0] {
    ALU_ADD   = 6'h00, ALU_SUB   = 6'h01, ALU_XOR   = 6'h02, ALU_OR    = 6'h03,
    ALU_AND   = 6'h04, ALU_SRA   = 6'h05, ALU_SRL   = 6'h06, ALU_SLL   = 6'h07,
    ALU_LTS   = 6'h08, ALU_LTU   = 6'h09, ALU_LES   = 6'h0A, ALU_LEU   = 6'h0B,
    ALU_GTS   = 6'h0C, ALU_GTU   = 6'h0D, ALU_GES   = 6'h0E, ALU_GEU   = 6'h0F,
    ALU_EQ    = 6'h10, ALU_NE    = 6'h11,
    ALU_SLTS  = 6'h12, ALU_SLTU  = 6'h13, ALU_SLETS = 6'h14, ALU_SLETU = 6'h15,
    ALU_MUL   = 6'h20, ALU_MULHU = 6'h21, ALU_DIVU  = 6'h22, ALU_REMU  = 6'h23
  } alu_op_e;

  // command towards the datapath
  typedef struct packed {
    alu_op_e     op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
  } alu_req_t;

  // captured result and status flags
  typedef struct packed {
    logic [31:0] result;
    logic        cmp;
    logic        illegal;
  } alu_rsp_t;

  // wishbone classic master to slave
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [REG_ADR_WIDTH-1:0] adr;
    logic [31:0]              dat;
  } wb_req_t;

  // wishbone classic slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // true for the iterative group
  function automatic logic is_multdiv_op(alu_op_e op);
    return (op == ALU_MUL) || (op == ALU_MULHU) || (op == ALU_DIVU) || (op == ALU_REMU);
  endfunction

endpackage

// ==== verilog/alu_core.sv ====
/* Integer ALU datapath */

`timescale 1ns/1ps

module alu_core
(
  input  alu_pkg::alu_req_t req_i,
  input  logic              multdiv_en_i,
  input  logic [32:0]       multdiv_operand_a_i,
  input  logic [32:0]       multdiv_operand_b_i,
  output logic [33:0]       adder_result_ext_o,
  output logic [31:0]       result_o,
  output logic              comparison_result_o
);

  alu_pkg::alu_op_e op;
  logic [31:0]      operand_a;
  logic [31:0]      operand_b;
  logic [31:0]      operand_a_rev;

  assign op        = req_i.op;
  assign operand_a = req_i.operand_a;
  assign operand_b = req_i.operand_b;

  // reversed operand a lets the right shifter do left shifts
  for (genvar k = 0; k < 32; k++)
  begin : g_rev_a
    assign operand_a_rev[k] = operand_a[31-k];
  end

  ////////////////////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////////////////////

  logic        adder_op_b_negate;
  logic [32:0] adder_in_a;
  logic [32:0] adder_in_b;
  logic [32:0] operand_b_neg;
  logic [31:0] adder_result;

  // subtract and every compare go through a - b
  always_comb
  begin
    adder_op_b_negate = 1'b0;
    unique case (op)
      alu_pkg::ALU_SUB,
      alu_pkg::ALU_EQ,    alu_pkg::ALU_NE,
      alu_pkg::ALU_GTU,   alu_pkg::ALU_GEU,
      alu_pkg::ALU_LTU,   alu_pkg::ALU_LEU,
      alu_pkg::ALU_GTS,   alu_pkg::ALU_GES,
      alu_pkg::ALU_LTS,   alu_pkg::ALU_LES,
      alu_pkg::ALU_SLTS,  alu_pkg::ALU_SLTU,
      alu_pkg::ALU_SLETS, alu_pkg::ALU_SLETU: adder_op_b_negate = 1'b1;
      default: ;
    endcase
  end

  // low bit of a is the carry in for the two's complement of b
  assign adder_in_a    = multdiv_en_i ? multdiv_operand_a_i : {operand_a, 1'b1};
  assign operand_b_neg = {operand_b, 1'b0} ^ {33{adder_op_b_negate}};
  assign adder_in_b    = multdiv_en_i ? multdiv_operand_b_i : operand_b_neg;

  // 34 bits so the multdiv unit sees the carry out
  assign adder_result_ext_o = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_result       = adder_result_ext_o[32:1];

  ////////////////////////////////////////////////////////////////////////////
  // shifter
  ////////////////////////////////////////////////////////////////////////////

  logic        shift_left;
  logic        shift_arithmetic;
  logic [31:0] shift_op_a;
  logic [32:0] shift_op_a_33;
  logic [32:0] shift_right_ext;
  logic [31:0] shift_left_result;
  logic [31:0] shift_result;

  assign shift_left       = (op == alu_pkg::ALU_SLL);
  assign shift_arithmetic = (op == alu_pkg::ALU_SRA);
  assign shift_op_a       = shift_left ? operand_a_rev : operand_a;

  // extra top bit carries the sign only for SRA
  assign shift_op_a_33   = {shift_arithmetic & shift_op_a[31], shift_op_a};
  // only the low 5 bits of b count
  assign shift_right_ext = $signed(shift_op_a_33) >>> operand_b[4:0];

  // undo the reversal for SLL
  for (genvar j = 0; j < 32; j++)
  begin : g_rev_res
    assign shift_left_result[j] = shift_right_ext[31-j];
  end

  assign shift_result = shift_left ? shift_left_result : shift_right_ext[31:0];

  ////////////////////////////////////////////////////////////////////////////
  // comparison
  ////////////////////////////////////////////////////////////////////////////

  logic is_equal;
  logic is_greater_equal;
  logic cmp_signed;
  logic cmp_result;

  always_comb
  begin
    cmp_signed = 1'b0;
    unique case (op)
      alu_pkg::ALU_GTS, alu_pkg::ALU_GES,
      alu_pkg::ALU_LTS, alu_pkg::ALU_LES,
      alu_pkg::ALU_SLTS, alu_pkg::ALU_SLETS: cmp_signed = 1'b1;
      default: ;
    endcase
  end

  assign is_equal = (adder_result == 32'b0);

  // same signs trust the difference, otherwise the sign of a decides
  always_comb
  begin
    if ((operand_a[31] ^ operand_b[31]) == 1'b0)
      is_greater_equal = ~adder_result[31];
    else
      is_greater_equal = operand_a[31] ^ cmp_signed;
  end

  always_comb
  begin
    cmp_result = is_equal;
    unique case (op)
      alu_pkg::ALU_EQ:  cmp_result = is_equal;
      alu_pkg::ALU_NE:  cmp_result = ~is_equal;
      alu_pkg::ALU_GTS,
      alu_pkg::ALU_GTU: cmp_result = is_greater_equal & ~is_equal;
      alu_pkg::ALU_GES,
      alu_pkg::ALU_GEU: cmp_result = is_greater_equal;
      alu_pkg::ALU_LTS, alu_pkg::ALU_SLTS,
      alu_pkg::ALU_LTU, alu_pkg::ALU_SLTU: cmp_result = ~is_greater_equal;
      alu_pkg::ALU_LES, alu_pkg::ALU_SLETS,
      alu_pkg::ALU_LEU, alu_pkg::ALU_SLETU: cmp_result = ~is_greater_equal | is_equal;
      default: ;
    endcase
  end

  assign comparison_result_o = cmp_result;

  ////////////////////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////////////////////

  // multdiv and unknown codes give zero here
  always_comb
  begin
    result_o = '0;
    unique case (op)
      alu_pkg::ALU_AND: result_o = operand_a & operand_b;
      alu_pkg::ALU_OR:  result_o = operand_a | operand_b;
      alu_pkg::ALU_XOR: result_o = operand_a ^ operand_b;
      alu_pkg::ALU_ADD,
      alu_pkg::ALU_SUB: result_o = adder_result;
      alu_pkg::ALU_SLL,
      alu_pkg::ALU_SRL,
      alu_pkg::ALU_SRA: result_o = shift_result;
      alu_pkg::ALU_EQ,    alu_pkg::ALU_NE,
      alu_pkg::ALU_GTU,   alu_pkg::ALU_GEU,
      alu_pkg::ALU_LTU,   alu_pkg::ALU_LEU,
      alu_pkg::ALU_GTS,   alu_pkg::ALU_GES,
      alu_pkg::ALU_LTS,   alu_pkg::ALU_LES,
      alu_pkg::ALU_SLTS,  alu_pkg::ALU_SLTU,
      alu_pkg::ALU_SLETS, alu_pkg::ALU_SLETU: result_o = {31'b0, cmp_result};
      default: ;
    endcase
  end

  // the iterative unit only borrows the adder for its own commands
  always_comb
  begin
    a_md_op: assert #0 (!multdiv_en_i || alu_pkg::is_multdiv_op(op))
      else $error("adder taken by multdiv unit during a non multdiv op");
  end

endmodule

// ==== verilog/multdiv_iter.sv ====
/* Iterative multiply and divide */

`timescale 1ns/1ps

module multdiv_iter
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  alu_pkg::alu_req_t req_i,
  input  logic [33:0]       adder_result_ext_i,
  output logic              multdiv_en_o,
  output logic [32:0]       multdiv_operand_a_o,
  output logic [32:0]       multdiv_operand_b_o,
  output logic              done_o,
  output logic [31:0]       result_o
);

  typedef enum logic [1:0] {MD_IDLE, MD_ITER, MD_FINISH} md_state_e;

  md_state_e   state_q;
  logic [5:0]  cnt_q;
  // mul keeps {partial product, multiplier}, div keeps {remainder, quotient}
  logic [63:0] acc_q;
  logic [63:0] acc_d;
  // multiplicand or divisor
  logic [31:0] operand_q;
  logic        is_div_q;
  logic        hi_sel_q;
  logic        div_ge;

  // adder operands per step
  always_comb
  begin
    if (is_div_q)
    begin
      // shifted remainder minus divisor, set low bits carry the +1
      multdiv_operand_a_o = {acc_q[62:31], 1'b1};
      multdiv_operand_b_o = {~operand_q, 1'b1};
    end
    else
    begin
      // partial product plus multiplicand when the multiplier bit is set
      multdiv_operand_a_o = {acc_q[63:32], 1'b0};
      multdiv_operand_b_o = {acc_q[0] ? operand_q : 32'b0, 1'b0};
    end
  end

  // bit 32 of the shifted remainder or the carry means no borrow
  assign div_ge = acc_q[63] | adder_result_ext_i[33];

  always_comb
  begin
    if (is_div_q)
      acc_d = {div_ge ? adder_result_ext_i[32:1] : acc_q[62:31], acc_q[30:0], div_ge};
    else
      acc_d = {adder_result_ext_i[33:1], acc_q[31:1]};
  end

  // step control
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      unique case (state_q)
        MD_IDLE:
        begin
          if (start_i)
          begin
            state_q <= MD_ITER;
            cnt_q   <= '0;
          end
        end
        MD_ITER:
        begin
          cnt_q <= cnt_q + 6'd1;
          if (cnt_q == 6'd31)
            state_q <= MD_FINISH;
        end
        default: state_q <= MD_IDLE;
      endcase
    end
  end

  // datapath registers
  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      acc_q     <= {32'b0, req_i.operand_a};
      operand_q <= req_i.operand_b;
      is_div_q  <= (req_i.op == alu_pkg::ALU_DIVU) || (req_i.op == alu_pkg::ALU_REMU);
      hi_sel_q  <= (req_i.op == alu_pkg::ALU_MULHU) || (req_i.op == alu_pkg::ALU_REMU);
    end
    else if (state_q == MD_ITER)
      acc_q <= acc_d;
  end

  assign multdiv_en_o = (state_q == MD_ITER);
  assign done_o       = (state_q == MD_FINISH);
  assign result_o     = hi_sel_q ? acc_q[63:32] : acc_q[31:0];

  a_cnt_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cnt_q <= 6'd32)
    else $error("multdiv step counter past 32");

  // load, 32 steps, then finish
  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_i |-> ##33 done_o)
    else $error("multdiv done not 33 cycles after start");

endmodule

// ==== verilog/alu_ctrl.sv ====
/* Command sequencer */

`timescale 1ns/1ps

module alu_ctrl #(
  parameter bit MULTDIV_EN = 1'b1
)
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  alu_pkg::alu_req_t req_i,
  input  logic [31:0]       alu_result_i,
  input  logic              alu_cmp_i,
  input  logic              md_done_i,
  input  logic [31:0]       md_result_i,
  output logic              md_start_o,
  output alu_pkg::alu_rsp_t rsp_o,
  output logic              done_o
);

  typedef enum logic [1:0] {CTRL_IDLE, CTRL_RUN_MD, CTRL_FINISH} ctrl_state_e;

  ctrl_state_e       state_q;
  alu_pkg::alu_rsp_t rsp_q;
  logic              is_alu;
  logic              is_cmp;
  logic              is_md;

  // classify the op code, anything unmatched is illegal
  always_comb
  begin
    is_alu = 1'b0;
    is_cmp = 1'b0;
    unique case (req_i.op)
      alu_pkg::ALU_ADD, alu_pkg::ALU_SUB,
      alu_pkg::ALU_XOR, alu_pkg::ALU_OR, alu_pkg::ALU_AND,
      alu_pkg::ALU_SRA, alu_pkg::ALU_SRL, alu_pkg::ALU_SLL: is_alu = 1'b1;
      alu_pkg::ALU_EQ,    alu_pkg::ALU_NE,
      alu_pkg::ALU_GTU,   alu_pkg::ALU_GEU,
      alu_pkg::ALU_LTU,   alu_pkg::ALU_LEU,
      alu_pkg::ALU_GTS,   alu_pkg::ALU_GES,
      alu_pkg::ALU_LTS,   alu_pkg::ALU_LES,
      alu_pkg::ALU_SLTS,  alu_pkg::ALU_SLTU,
      alu_pkg::ALU_SLETS, alu_pkg::ALU_SLETU:
      begin
        is_alu = 1'b1;
        is_cmp = 1'b1;
      end
      default: ;
    endcase
  end

  // multdiv codes count only when the unit is built
  assign is_md      = MULTDIV_EN && alu_pkg::is_multdiv_op(req_i.op);
  assign md_start_o = start_i && (state_q == CTRL_IDLE) && is_md;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= CTRL_IDLE;
      rsp_q   <= '0;
    end
    else
    begin
      unique case (state_q)
        CTRL_IDLE:
        begin
          if (start_i && is_md)
            state_q <= CTRL_RUN_MD;
          else if (start_i)
          begin
            // single cycle op or illegal code, result lands right away
            rsp_q.result  <= is_alu ? alu_result_i : 32'b0;
            rsp_q.cmp     <= is_cmp & alu_cmp_i;
            rsp_q.illegal <= ~is_alu;
            state_q       <= CTRL_FINISH;
          end
        end
        CTRL_RUN_MD:
        begin
          if (md_done_i)
          begin
            rsp_q.result  <= md_result_i;
            rsp_q.cmp     <= 1'b0;
            rsp_q.illegal <= 1'b0;
            state_q       <= CTRL_FINISH;
          end
        end
        default: state_q <= CTRL_IDLE;
      endcase
    end
  end

  assign rsp_o  = rsp_q;
  assign done_o = (state_q == CTRL_FINISH);

  // multdiv completion only while its command is still outstanding here
  a_done_after_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    md_done_i |-> state_q == CTRL_RUN_MD)
    else $error("multdiv done without an outstanding command");

endmodule

// ==== verilog/wb_alu_regs.sv ====
/* Wishbone register file */

`timescale 1ns/1ps

module wb_alu_regs
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  alu_pkg::wb_req_t  wb_req_i,
  input  logic              done_i,
  input  alu_pkg::alu_rsp_t rsp_i,
  output alu_pkg::wb_rsp_t  wb_rsp_o,
  output logic              start_o,
  output alu_pkg::alu_req_t req_o
);

  logic                              active;
  logic                              cmd_write;
  logic                              wr_first;
  logic                              ack_q;
  // command accepted and not yet finished
  logic                              cmd_busy_q;
  logic [31:0]                       opa_q;
  logic [31:0]                       opb_q;
  logic [alu_pkg::ALU_OP_WIDTH-1:0]  op_q;
  logic [31:0]                       rd_data;

  assign active    = wb_req_i.cyc & wb_req_i.stb;
  assign cmd_write = active & wb_req_i.we & (wb_req_i.adr == alu_pkg::REG_CMD);
  assign wr_first  = active & wb_req_i.we & ~ack_q;

  // one pulse per command write
  assign start_o = cmd_write & ~cmd_busy_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q      <= 1'b0;
      cmd_busy_q <= 1'b0;
      opa_q      <= '0;
      opb_q      <= '0;
      op_q       <= '0;
    end
    else
    begin
      // plain accesses ack one cycle after stb
      ack_q <= active & ~ack_q & ~cmd_write;
      if (start_o)
        cmd_busy_q <= 1'b1;
      else if (done_i)
        cmd_busy_q <= 1'b0;
      if (wr_first && wb_req_i.adr == alu_pkg::REG_OPA)
        opa_q <= wb_req_i.dat;
      if (wr_first && wb_req_i.adr == alu_pkg::REG_OPB)
        opb_q <= wb_req_i.dat;
      if (start_o)
        op_q <= wb_req_i.dat[alu_pkg::ALU_OP_WIDTH-1:0];
    end
  end

  // read mux, status bit 2 is the busy flag
  always_comb
  begin
    unique case (wb_req_i.adr)
      alu_pkg::REG_OPA:    rd_data = opa_q;
      alu_pkg::REG_OPB:    rd_data = opb_q;
      alu_pkg::REG_RESULT: rd_data = rsp_i.result;
      alu_pkg::REG_STATUS: rd_data = {29'b0, cmd_busy_q, rsp_i.illegal, rsp_i.cmp};
      default:             rd_data = '0;
    endcase
  end

  // command write acks together with done
  assign wb_rsp_o = '{ack: ack_q | done_i, dat: rd_data};

  // op comes straight off the bus in the start cycle
  assign req_o = '{
    op:        start_o ? alu_pkg::alu_op_e'(wb_req_i.dat[alu_pkg::ALU_OP_WIDTH-1:0])
                       : alu_pkg::alu_op_e'(op_q),
    operand_a: opa_q,
    operand_b: opb_q
  };

  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_rsp_o.ack |-> wb_req_i.cyc && wb_req_i.stb)
    else $error("ack outside an active wishbone cycle");

endmodule

// ==== verilog/alu_cop_top.sv ====
/* ALU coprocessor top */

`timescale 1ns/1ps

module alu_cop_top #(
  parameter bit MULTDIV_EN = 1'b1
)
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  alu_pkg::wb_req_t wb_req_i,
  output alu_pkg::wb_rsp_t wb_rsp_o
);

  logic              start;
  logic              done;
  alu_pkg::alu_req_t alu_req;
  alu_pkg::alu_rsp_t alu_rsp;
  logic              md_start;
  logic              md_done;
  logic [31:0]       md_result;
  logic              multdiv_en;
  logic [32:0]       md_operand_a;
  logic [32:0]       md_operand_b;
  logic [33:0]       adder_result_ext;
  logic [31:0]       alu_result;
  logic              alu_cmp;

  wb_alu_regs u_wb_alu_regs (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_req_i (wb_req_i),
    .done_i   (done),
    .rsp_i    (alu_rsp),
    .wb_rsp_o (wb_rsp_o),
    .start_o  (start),
    .req_o    (alu_req)
  );

  alu_ctrl #(
    .MULTDIV_EN (MULTDIV_EN)
  ) u_alu_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start),
    .req_i        (alu_req),
    .alu_result_i (alu_result),
    .alu_cmp_i    (alu_cmp),
    .md_done_i    (md_done),
    .md_result_i  (md_result),
    .md_start_o   (md_start),
    .rsp_o        (alu_rsp),
    .done_o       (done)
  );

  alu_core u_alu_core (
    .req_i               (alu_req),
    .multdiv_en_i        (multdiv_en),
    .multdiv_operand_a_i (md_operand_a),
    .multdiv_operand_b_i (md_operand_b),
    .adder_result_ext_o  (adder_result_ext),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp)
  );

  // multiply/divide unit only when enabled
  if (MULTDIV_EN)
  begin : g_multdiv
    multdiv_iter u_multdiv_iter (
      .clk_i               (clk_i),
      .arst_n_i            (arst_n_i),
      .start_i             (md_start),
      .req_i               (alu_req),
      .adder_result_ext_i  (adder_result_ext),
      .multdiv_en_o        (multdiv_en),
      .multdiv_operand_a_o (md_operand_a),
      .multdiv_operand_b_o (md_operand_b),
      .done_o              (md_done),
      .result_o            (md_result)
    );
  end
  else
  begin : g_no_multdiv
    // adder stays with the ALU, ctrl never waits on multdiv
    assign multdiv_en   = 1'b0;
    assign md_operand_a = '0;
    assign md_operand_b = '0;
    assign md_done      = 1'b0;
    assign md_result    = '0;
  end

endmodule

// ==== tb/tb_alu_cop_bus.svh ====
/* Wishbone master tasks */

`ifndef TB_ALU_COP_BUS_SVH
`define TB_ALU_COP_BUS_SVH

  // longest legal wait is a multdiv command of 34 cycles
  localparam int ACK_TIMEOUT = 100;

  // single word write, held until ack has been sampled on a rising edge
  task automatic write_reg(input logic [4:0] adr, input logic [31:0] dat);
    int waited;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    waited = 0;
    @(negedge clk);
    // ack seen here is what the next rising edge samples
    while (!wb_rsp.ack && waited < ACK_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!wb_rsp.ack)
      stop_run($sformatf("write to address 0x%h got no ack within %0d cycles",
                         adr, ACK_TIMEOUT));
    else
    begin
      // stay on the bus through the sampling edge, then release
      @(negedge clk);
      wb_req = '0;
    end
  endtask

  // single word read, data taken while ack is high
  task automatic read_reg(input logic [4:0] adr, output logic [31:0] dat);
    int waited;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'b0};
    waited = 0;
    @(negedge clk);
    while (!wb_rsp.ack && waited < ACK_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!wb_rsp.ack)
      stop_run($sformatf("read from address 0x%h got no ack within %0d cycles",
                         adr, ACK_TIMEOUT));
    else
    begin
      dat = wb_rsp.dat;
      @(negedge clk);
      wb_req = '0;
    end
  endtask

`endif

// ==== tb/tb_alu_cop.sv ====
/* ALU coprocessor testbench */

`timescale 1ns/1ps

module tb_alu_cop;

  logic             clk;
  logic             arst_n;
  alu_pkg::wb_req_t wb_req;
  alu_pkg::wb_rsp_t wb_rsp;

  // expected values, set before each access starts
  logic [31:0] exp_result;
  logic [31:0] exp_status;
  int          exp_lat;
  // rising edges since stb went up in the current access
  int          stb_cnt;
  logic [31:0] lcg_state;

  logic bus_ack;
  logic read_ack;

  alu_cop_top #(
    .MULTDIV_EN (1'b1)
  ) u_alu_cop_top (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  always #50 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  `include "tb_alu_cop_bus.svh"

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] ref_result(input logic [5:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      alu_pkg::ALU_ADD:   return a + b;
      alu_pkg::ALU_SUB:   return a - b;
      alu_pkg::ALU_XOR:   return a ^ b;
      alu_pkg::ALU_OR:    return a | b;
      alu_pkg::ALU_AND:   return a & b;
      // shift amount is b mod 32
      alu_pkg::ALU_SRA:   return $signed(a) >>> b[4:0];
      alu_pkg::ALU_SRL:   return a >> b[4:0];
      alu_pkg::ALU_SLL:   return a << b[4:0];
      alu_pkg::ALU_LTS,
      alu_pkg::ALU_SLTS:  return {31'b0, ($signed(a) < $signed(b))};
      alu_pkg::ALU_LTU,
      alu_pkg::ALU_SLTU:  return {31'b0, (a < b)};
      alu_pkg::ALU_LES,
      alu_pkg::ALU_SLETS: return {31'b0, ($signed(a) <= $signed(b))};
      alu_pkg::ALU_LEU,
      alu_pkg::ALU_SLETU: return {31'b0, (a <= b)};
      alu_pkg::ALU_GTS:   return {31'b0, ($signed(a) > $signed(b))};
      alu_pkg::ALU_GTU:   return {31'b0, (a > b)};
      alu_pkg::ALU_GES:   return {31'b0, ($signed(a) >= $signed(b))};
      alu_pkg::ALU_GEU:   return {31'b0, (a >= b)};
      alu_pkg::ALU_EQ:    return {31'b0, (a == b)};
      alu_pkg::ALU_NE:    return {31'b0, (a != b)};
      alu_pkg::ALU_MUL:   return prod[31:0];
      alu_pkg::ALU_MULHU: return prod[63:32];
      // zero divisor gives all ones and the dividend
      alu_pkg::ALU_DIVU:  return (b == 32'b0) ? 32'hFFFF_FFFF : a / b;
      alu_pkg::ALU_REMU:  return (b == 32'b0) ? a : a % b;
      default:            return 32'b0;
    endcase
  endfunction

  // bit 0 cmp, bit 1 illegal, bit 2 busy never seen by a read
  function automatic logic [31:0] status_word(input logic [5:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
    logic [31:0] res;
    logic        cmp;
    logic        illegal;
    res     = ref_result(op, a, b);
    cmp     = (op >= alu_pkg::ALU_LTS && op <= alu_pkg::ALU_SLETU) && res[0];
    illegal = !(op <= alu_pkg::ALU_SLETU || (op >= alu_pkg::ALU_MUL && op <= alu_pkg::ALU_REMU));
    return {29'b0, 1'b0, illegal, cmp};
  endfunction

  // load, 32 steps and finish for multdiv, one cycle otherwise
  function automatic int cmd_latency(input logic [5:0] op);
    return (op >= alu_pkg::ALU_MUL && op <= alu_pkg::ALU_REMU) ? 34 : 1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  assign bus_ack  = wb_req.cyc & wb_req.stb & wb_rsp.ack;
  assign read_ack = bus_ack & ~wb_req.we;

  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      stb_cnt <= 0;
    else if (wb_req.cyc && wb_req.stb)
      stb_cnt <= stb_cnt + 1;
    else
      stb_cnt <= 0;
  end

  a_result: assert property (@(posedge clk) disable iff (!arst_n)
    read_ack && wb_req.adr == alu_pkg::REG_RESULT |-> wb_rsp.dat == exp_result)
    else stop_run($sformatf("** Error: wb_rsp.dat at REG_RESULT is 0x%h, expected 0x%h",
                            $sampled(wb_rsp.dat), $sampled(exp_result)));

  a_status: assert property (@(posedge clk) disable iff (!arst_n)
    read_ack && wb_req.adr == alu_pkg::REG_STATUS |-> wb_rsp.dat == exp_status)
    else stop_run($sformatf("** Error: wb_rsp.dat at REG_STATUS is 0x%h, expected 0x%h",
                            $sampled(wb_rsp.dat), $sampled(exp_status)));

  // ack delay counted in rising edges from the first active cycle
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    bus_ack |-> stb_cnt == exp_lat)
    else stop_run($sformatf("** Error: wb_rsp.ack latency is 0x%h, expected 0x%h",
                            $sampled(stb_cnt), $sampled(exp_lat)));

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_random(output logic [31:0] w);
    // upper LCG bits only, the low ones repeat too fast
    lcg_state = lcg_next(lcg_state);
    w[31:16]  = lcg_state[31:16];
    lcg_state = lcg_next(lcg_state);
    w[15:0]   = lcg_state[31:16];
  endtask

  task automatic run_command(input logic [5:0] op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] rd;
    exp_lat = 1;
    write_reg(alu_pkg::REG_OPA, a);
    write_reg(alu_pkg::REG_OPB, b);
    exp_result = ref_result(op, a, b);
    exp_status = status_word(op, a, b);
    exp_lat    = cmd_latency(op);
    write_reg(alu_pkg::REG_CMD, {26'b0, op});
    exp_lat = 1;
    read_reg(alu_pkg::REG_RESULT, rd);
    read_reg(alu_pkg::REG_STATUS, rd);
  endtask

  task automatic compare_sweep(input logic [31:0] a, input logic [31:0] b);
    for (int c = alu_pkg::ALU_LTS; c <= alu_pkg::ALU_SLETU; c++)
      run_command(c[5:0], a, b);
  endtask

  task automatic muldiv_sweep(input logic [31:0] a, input logic [31:0] b);
    for (int c = alu_pkg::ALU_MUL; c <= alu_pkg::ALU_REMU; c++)
      run_command(c[5:0], a, b);
  endtask

  initial
  begin
    logic [31:0] a;
    logic [31:0] b;
    clk        = 1'b0;
    arst_n     = 1'b0;
    wb_req     = '0;
    lcg_state  = 32'd81;
    exp_result = '0;
    exp_status = '0;
    exp_lat    = 1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // logic, add and subtract
    for (int i = 0; i < 6; i++)
    begin
      for (int c = alu_pkg::ALU_ADD; c <= alu_pkg::ALU_AND; c++)
      begin
        next_random(a);
        next_random(b);
        run_command(c[5:0], a, b);
      end
    end
    run_command(alu_pkg::ALU_ADD, 32'hFFFF_FFFF, 32'h0000_0001);
    run_command(alu_pkg::ALU_SUB, 32'h0000_0000, 32'h0000_0001);

    // shifts, upper bits of b must not matter
    for (int i = 0; i < 4; i++)
    begin
      next_random(a);
      next_random(b);
      for (int c = alu_pkg::ALU_SRA; c <= alu_pkg::ALU_SLL; c++)
        run_command(c[5:0], a, b);
    end
    for (int c = alu_pkg::ALU_SRA; c <= alu_pkg::ALU_SLL; c++)
    begin
      run_command(c[5:0], 32'h8000_0000, 32'd31);
      run_command(c[5:0], 32'hFFFF_FFFF, 32'h0000_0024);
    end

    // comparisons with equal operands and mixed signs
    next_random(a);
    compare_sweep(a, a);
    compare_sweep(32'h8000_0000, 32'h0000_0001);
    compare_sweep(32'h0000_0001, 32'h8000_0000);
    compare_sweep(32'h0000_0000, 32'hFFFF_FFFF);
    compare_sweep(32'hFFFF_FFFF, 32'hFFFF_FFFE);
    next_random(a);
    next_random(b);
    compare_sweep(a, b);

    // multiply and divide, random then corners
    for (int i = 0; i < 4; i++)
    begin
      next_random(a);
      next_random(b);
      muldiv_sweep(a, b);
    end
    next_random(b);
    muldiv_sweep(a, {16'b0, b[15:0]});
    muldiv_sweep(32'hFFFF_FFFF, 32'hFFFF_FFFF);
    muldiv_sweep(32'h8000_0000, 32'h0000_0002);
    muldiv_sweep(32'h0000_3039, 32'h0000_0000);
    muldiv_sweep(32'h0000_0000, 32'h0000_0000);
    muldiv_sweep(32'h0000_0005, 32'hFFFF_FFFF);

    // undefined codes, each followed by a legal command
    next_random(a);
    next_random(b);
    run_command(6'h3F, a, b);
    run_command(alu_pkg::ALU_ADD, a, b);
    run_command(6'h16, a, b);
    run_command(alu_pkg::ALU_SLTU, b, a);
    run_command(6'h1F, a, b);
    run_command(alu_pkg::ALU_MUL, a, b);

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tb
verilog/alu_pkg.sv
verilog/alu_core.sv
verilog/multdiv_iter.sv
verilog/alu_ctrl.sv
verilog/wb_alu_regs.sv
verilog/alu_cop_top.sv
tb/tb_alu_cop.sv
